// File: Makefile
TOOL     ?= verilator
FLAGS    ?= --binary --timing -j 0
TOP      ?= tb_top
FILELIST ?= project.f
LOG      ?= sim.log
OBJDIR   ?= obj_dir

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o $(TOP)
	./$(OBJDIR)/$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: design/chan_if.sv
// host access path from the bus port to one pointer channel
`default_nettype none
`timescale 1ns/10ps

interface chan_if;

logic                                   wr_stb;     // byte write, one cycle
logic                                   rd_stb;     // end of host read, one cycle
vram_regs_pkg::reg_field_e              field;      // addressed field
logic                                   bytesel;    // 0 even/high, 1 odd/low
logic [vram_regs_pkg::BYTE_W-1:0]       wbyte;      // written byte

logic [vram_regs_pkg::ADDR_W-1:0]       addr;       // current pointer
logic [vram_regs_pkg::WORD_W-1:0]       incr;       // pointer step
logic [vram_regs_pkg::WORD_W-1:0]       rdata;      // last word read
logic                                   busy;       // access in flight

modport host (
    output wr_stb, rd_stb, field, bytesel, wbyte,
    input  addr, incr, rdata, busy
);

modport chan (
    input  wr_stb, rd_stb, field, bytesel, wbyte,
    output addr, incr, rdata, busy
);

endinterface

`default_nettype wire

// File: design/host_bus_port.sv
// host bus port, syncs chip select, latches accesses and muxes read-back bytes
`default_nettype none
`timescale 1ns/10ps

module host_bus_port (
    input  wire logic                                   clk,
    input  wire logic                                   reset_i,
    input  wire logic                                   bus_cs_n_i,     // async select
    input  wire logic                                   bus_rd_nwr_i,   // 1 read, 0 write
    input  wire logic [vram_regs_pkg::REG_NUM_W-1:0]    bus_reg_num_i,  // register number
    input  wire logic                                   bus_bytesel_i,  // 0 even, 1 odd
    input  wire logic [vram_regs_pkg::BYTE_W-1:0]       bus_data_i,     // write byte
    output      logic [vram_regs_pkg::BYTE_W-1:0]       bus_data_o,     // read-back byte
    chan_if.host                                        chans [vram_regs_pkg::NUM_CHANNELS]
);

logic [vram_regs_pkg::SYNC_STAGES-1:0]  cs_sync;        // shift chain, idles high
logic                                   cs_prev;        // last synced level
logic                                   cs_fall;        // access start
logic                                   cs_rise;        // access end

logic [vram_regs_pkg::REG_NUM_W-1:0]    lat_reg_num;    // latched at cs fall
logic                                   lat_bytesel;
logic                                   lat_rd_nwr;
logic [vram_regs_pkg::BYTE_W-1:0]       lat_byte;       // payload, no reset
logic                                   wr_pulse;       // before channel routing
logic                                   rd_pulse;

logic [vram_regs_pkg::CHAN_IDX_W-1:0]   lat_chan;
vram_regs_pkg::reg_field_e              lat_field;

logic [vram_regs_pkg::ADDR_W-1:0]       chan_addr  [vram_regs_pkg::NUM_CHANNELS];
logic [vram_regs_pkg::WORD_W-1:0]       chan_incr  [vram_regs_pkg::NUM_CHANNELS];
logic [vram_regs_pkg::WORD_W-1:0]       chan_rdata [vram_regs_pkg::NUM_CHANNELS];
logic [vram_regs_pkg::NUM_CHANNELS-1:0] busy_bits;
logic [vram_regs_pkg::WORD_W-1:0]       rd_word;        // word before byte select

assign cs_fall   = cs_prev & ~cs_sync[vram_regs_pkg::SYNC_STAGES-1];
assign cs_rise   = ~cs_prev & cs_sync[vram_regs_pkg::SYNC_STAGES-1];
assign lat_chan  = lat_reg_num[vram_regs_pkg::REG_NUM_W-1 -: vram_regs_pkg::CHAN_IDX_W];
assign lat_field = vram_regs_pkg::reg_field_e'(lat_reg_num[1:0]);

always_ff @(posedge clk) begin
    if (reset_i) begin
        cs_sync     <= '1;                              // deselected
        cs_prev     <= 1'b1;
        lat_reg_num <= '0;
        lat_bytesel <= 1'b0;
        lat_rd_nwr  <= 1'b0;
        wr_pulse    <= 1'b0;
        rd_pulse    <= 1'b0;
    end else begin
        cs_sync  <= {cs_sync[vram_regs_pkg::SYNC_STAGES-2:0], bus_cs_n_i};
        cs_prev  <= cs_sync[vram_regs_pkg::SYNC_STAGES-1];
        wr_pulse <= cs_fall & ~bus_rd_nwr_i;            // 3 cycles after cs_n falls
        rd_pulse <= cs_rise & lat_rd_nwr;               // read done, may pre-read
        if (cs_fall) begin
            lat_reg_num <= bus_reg_num_i;               // bus stable by now
            lat_bytesel <= bus_bytesel_i;
            lat_rd_nwr  <= bus_rd_nwr_i;
        end
    end
end

always_ff @(posedge clk) begin
    if (cs_fall) begin
        lat_byte <= bus_data_i;
    end
end

// fan out to channels, index 3 has no channel
for (genvar i = 0; i < vram_regs_pkg::NUM_CHANNELS; i++) begin : g_chan
    assign chans[i].wr_stb  = wr_pulse & (int'(lat_chan) == i);
    assign chans[i].rd_stb  = rd_pulse & (int'(lat_chan) == i);
    assign chans[i].field   = lat_field;
    assign chans[i].bytesel = lat_bytesel;
    assign chans[i].wbyte   = lat_byte;
    assign chan_addr[i]     = chans[i].addr;            // gathered for the read mux
    assign chan_incr[i]     = chans[i].incr;
    assign chan_rdata[i]    = chans[i].rdata;
    assign busy_bits[i]     = chans[i].busy;
end

always_comb begin
    rd_word = '0;                                       // reserved reads zero
    if (lat_reg_num == vram_regs_pkg::STATUS_REG_NUM) begin
        rd_word = vram_regs_pkg::WORD_W'(busy_bits);    // busy in low byte
    end else if (int'(lat_chan) < vram_regs_pkg::NUM_CHANNELS) begin
        case (lat_field)
            vram_regs_pkg::FIELD_INCR: rd_word = chan_incr[lat_chan];
            vram_regs_pkg::FIELD_ADDR: rd_word = chan_addr[lat_chan];
            vram_regs_pkg::FIELD_DATA: rd_word = chan_rdata[lat_chan];
            vram_regs_pkg::FIELD_RSVD: rd_word = '0;
            default:                   rd_word = '0;
        endcase
    end
end

// even byte is the high half
assign bus_data_o = lat_bytesel ? rd_word[vram_regs_pkg::BYTE_W-1:0]
                                : rd_word[vram_regs_pkg::WORD_W-1:vram_regs_pkg::BYTE_W];

endmodule

`default_nettype wire

// File: design/vram_channel.sv
// vram pointer channel, address/increment registers and request sequencer
`default_nettype none
`timescale 1ns/10ps

module vram_channel (
    input  wire logic   clk,
    input  wire logic   reset_i,
    chan_if.chan        host,           // decoded host accesses
    vram_req_if.chan    vram            // toward the arbiter
);

vram_regs_pkg::chan_state_e             state;

logic [vram_regs_pkg::ADDR_W-1:0]       addr_r;         // pointer, steps on ack
logic [vram_regs_pkg::WORD_W-1:0]       incr_r;         // step size
logic [vram_regs_pkg::WORD_W-1:0]       rdata_r;        // last read word
logic [vram_regs_pkg::BYTE_W-1:0]       data_even;      // high byte of DATA write
logic                                   req_wr;         // current access is a write
logic [vram_regs_pkg::ADDR_W-1:0]       req_addr;       // held for the whole handshake
logic [vram_regs_pkg::WORD_W-1:0]       req_wdata;

logic                                   launch_rd;
logic                                   launch_wr;
logic [vram_regs_pkg::ADDR_W-1:0]       launch_addr;

// commands only start from idle, busy ones drop
always_comb begin
    launch_rd   = 1'b0;
    launch_wr   = 1'b0;
    launch_addr = addr_r;
    if (state == vram_regs_pkg::CH_IDLE && host.bytesel) begin
        if (host.wr_stb && host.field == vram_regs_pkg::FIELD_ADDR) begin
            launch_rd   = 1'b1;                         // pre-read at the new address
            launch_addr = {addr_r[vram_regs_pkg::ADDR_W-1:vram_regs_pkg::BYTE_W], host.wbyte};
        end
        if (host.wr_stb && host.field == vram_regs_pkg::FIELD_DATA) begin
            launch_wr = 1'b1;
        end
        if (host.rd_stb && host.field == vram_regs_pkg::FIELD_DATA) begin
            launch_rd = 1'b1;                           // refill after odd read
        end
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        state   <= vram_regs_pkg::CH_IDLE;
        addr_r  <= '0;
        incr_r  <= '0;
        rdata_r <= '0;
        req_wr  <= 1'b0;
    end else begin
        case (state)
            vram_regs_pkg::CH_IDLE: begin
                if (launch_rd || launch_wr) begin
                    state  <= vram_regs_pkg::CH_REQ;    // req up next cycle
                    req_wr <= launch_wr;
                end
            end
            vram_regs_pkg::CH_REQ: begin
                if (vram.ack) begin
                    state  <= vram_regs_pkg::CH_RELEASE;
                    addr_r <= addr_r + incr_r;          // every access steps
                    if (!req_wr) begin
                        rdata_r <= vram.rdata;
                    end
                end
            end
            vram_regs_pkg::CH_RELEASE: begin
                if (!vram.ack) begin
                    state <= vram_regs_pkg::CH_IDLE;
                end
            end
            default: state <= vram_regs_pkg::CH_IDLE;
        endcase

        // register bytes land even while busy, after the step above
        if (host.wr_stb) begin
            case (host.field)
                vram_regs_pkg::FIELD_INCR: begin
                    if (host.bytesel) incr_r[vram_regs_pkg::BYTE_W-1:0] <= host.wbyte;
                    else incr_r[vram_regs_pkg::WORD_W-1:vram_regs_pkg::BYTE_W] <= host.wbyte;
                end
                vram_regs_pkg::FIELD_ADDR: begin
                    if (host.bytesel) addr_r[vram_regs_pkg::BYTE_W-1:0] <= host.wbyte;
                    else addr_r[vram_regs_pkg::ADDR_W-1:vram_regs_pkg::BYTE_W] <= host.wbyte;
                end
                default: ;                              // DATA handled below
            endcase
        end
    end
end

// payload registers
always_ff @(posedge clk) begin
    if (host.wr_stb && !host.bytesel && host.field == vram_regs_pkg::FIELD_DATA) begin
        data_even <= host.wbyte;
    end
    if (launch_rd || launch_wr) begin
        req_addr  <= launch_addr;
        req_wdata <= {data_even, host.wbyte};           // used only by writes
    end
end

assign vram.req    = (state == vram_regs_pkg::CH_REQ);
assign vram.wr     = req_wr;
assign vram.addr   = req_addr;
assign vram.wdata  = req_wdata;

assign host.addr   = addr_r;
assign host.incr   = incr_r;
assign host.rdata  = rdata_r;
assign host.busy   = (state != vram_regs_pkg::CH_IDLE);   // launch until ack low

endmodule

`default_nettype wire

// File: design/vram_port_arbiter.sv
// fixed-priority arbiter onto the external four-phase vram port
`default_nettype none
`timescale 1ns/10ps

module vram_port_arbiter (
    input  wire logic                                   clk,
    input  wire logic                                   reset_i,
    vram_req_if.arb                                     reqs [vram_regs_pkg::NUM_CHANNELS],
    output      logic                                   vram_req_o,
    output      logic                                   vram_wr_o,
    output      logic [vram_regs_pkg::ADDR_W-1:0]       vram_addr_o,
    output      logic [vram_regs_pkg::WORD_W-1:0]       vram_wdata_o,
    input  wire logic                                   vram_ack_i,
    input  wire logic [vram_regs_pkg::WORD_W-1:0]       vram_rdata_i
);

vram_regs_pkg::arb_state_e              state;
logic [vram_regs_pkg::CHAN_IDX_W-1:0]   grant;          // owner of the port
logic [vram_regs_pkg::CHAN_IDX_W-1:0]   sel;            // lowest requester
logic [vram_regs_pkg::NUM_CHANNELS-1:0] req_vec;
logic [vram_regs_pkg::NUM_CHANNELS-1:0] wr_vec;
logic [vram_regs_pkg::ADDR_W-1:0]       addr_arr  [vram_regs_pkg::NUM_CHANNELS];
logic [vram_regs_pkg::WORD_W-1:0]       wdata_arr [vram_regs_pkg::NUM_CHANNELS];

for (genvar i = 0; i < vram_regs_pkg::NUM_CHANNELS; i++) begin : g_req
    assign req_vec[i]    = reqs[i].req;
    assign wr_vec[i]     = reqs[i].wr;
    assign addr_arr[i]   = reqs[i].addr;
    assign wdata_arr[i]  = reqs[i].wdata;
    // ack passes straight through to the owner
    assign reqs[i].ack   = (state != vram_regs_pkg::ARB_IDLE) && (int'(grant) == i)
                           && vram_ack_i;
    assign reqs[i].rdata = vram_rdata_i;                // qualified by ack
end

// channel 0 wins
always_comb begin
    sel = '0;
    for (int i = vram_regs_pkg::NUM_CHANNELS - 1; i >= 0; i--) begin
        if (req_vec[i]) sel = i[vram_regs_pkg::CHAN_IDX_W-1:0];
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        state      <= vram_regs_pkg::ARB_IDLE;
        grant      <= '0;
        vram_req_o <= 1'b0;
        vram_wr_o  <= 1'b0;
    end else begin
        case (state)
            vram_regs_pkg::ARB_IDLE: begin
                if (|req_vec) begin
                    grant      <= sel;
                    vram_wr_o  <= wr_vec[sel];
                    vram_req_o <= 1'b1;                 // one cycle after grant
                    state      <= vram_regs_pkg::ARB_BUSY;
                end
            end
            vram_regs_pkg::ARB_BUSY: begin
                if (!req_vec[grant]) begin              // owner saw ack
                    vram_req_o <= 1'b0;
                    state      <= vram_regs_pkg::ARB_DRAIN;
                end
            end
            vram_regs_pkg::ARB_DRAIN: begin
                if (!vram_ack_i) state <= vram_regs_pkg::ARB_IDLE;
            end
            default: state <= vram_regs_pkg::ARB_IDLE;
        endcase
    end
end

// address and data captured with the grant
always_ff @(posedge clk) begin
    if (state == vram_regs_pkg::ARB_IDLE && |req_vec) begin
        vram_addr_o  <= addr_arr[sel];
        vram_wdata_o <= wdata_arr[sel];
    end
end

endmodule

`default_nettype wire

// File: design/vram_regs_pkg.sv
// vram register port shared widths, register map and state encodings
`default_nettype none

package vram_regs_pkg;

// bus and datapath widths
localparam int BYTE_W         = 8;      // host bus byte
localparam int WORD_W         = 16;     // register and vram word
localparam int ADDR_W         = 16;     // vram word address
localparam int REG_NUM_W      = 4;      // host register number

// channel layout
localparam int NUM_CHANNELS   = 3;      // pointer channels
localparam int CHAN_IDX_W     = 2;      // upper bits of reg number
localparam int SYNC_STAGES    = 2;      // cs_n synchronizer depth

localparam logic [REG_NUM_W-1:0] STATUS_REG_NUM = 4'd12;   // channel 3, field 0

// low two bits of a register number
typedef enum logic [1:0] {
    FIELD_INCR = 2'd0,                  // address increment
    FIELD_ADDR = 2'd1,                  // address, odd write pre-reads
    FIELD_DATA = 2'd2,                  // vram data window
    FIELD_RSVD = 2'd3                   // reads zero
} reg_field_e;

// per-channel request sequencer
typedef enum logic [1:0] {
    CH_IDLE,                            // no access outstanding
    CH_REQ,                             // req high, waiting for ack
    CH_RELEASE                          // req low, waiting for ack low
} chan_state_e;

// external port sequencer
typedef enum logic [1:0] {
    ARB_IDLE,                           // free to grant
    ARB_BUSY,                           // vram_req_o raised
    ARB_DRAIN                           // req dropped, waiting for ack low
} arb_state_e;

endpackage

`default_nettype wire

// File: design/vram_regs_top.sv
// vram register port top, host bus decode, pointer channels and vram arbiter
`default_nettype none
`timescale 1ns/10ps

module vram_regs_top (
    input  wire logic                                   clk,
    input  wire logic                                   reset_i,
    // host bus
    input  wire logic                                   bus_cs_n_i,
    input  wire logic                                   bus_rd_nwr_i,
    input  wire logic [vram_regs_pkg::REG_NUM_W-1:0]    bus_reg_num_i,
    input  wire logic                                   bus_bytesel_i,
    input  wire logic [vram_regs_pkg::BYTE_W-1:0]       bus_data_i,
    output      logic [vram_regs_pkg::BYTE_W-1:0]       bus_data_o,
    // vram, four-phase, this side requests
    output      logic                                   vram_req_o,
    output      logic                                   vram_wr_o,
    output      logic [vram_regs_pkg::ADDR_W-1:0]       vram_addr_o,
    output      logic [vram_regs_pkg::WORD_W-1:0]       vram_wdata_o,
    input  wire logic                                   vram_ack_i,
    input  wire logic [vram_regs_pkg::WORD_W-1:0]       vram_rdata_i
);

chan_if     chans [vram_regs_pkg::NUM_CHANNELS] ();     // bus port to channels
vram_req_if vreqs [vram_regs_pkg::NUM_CHANNELS] ();     // channels to arbiter

host_bus_port host_bus_port_inst (
    .clk            (clk),
    .reset_i        (reset_i),
    .bus_cs_n_i     (bus_cs_n_i),
    .bus_rd_nwr_i   (bus_rd_nwr_i),
    .bus_reg_num_i  (bus_reg_num_i),
    .bus_bytesel_i  (bus_bytesel_i),
    .bus_data_i     (bus_data_i),
    .bus_data_o     (bus_data_o),
    .chans          (chans)
);

// identical pointer channels
for (genvar i = 0; i < vram_regs_pkg::NUM_CHANNELS; i++) begin : g_channel
    vram_channel vram_channel_inst (
        .clk        (clk),
        .reset_i    (reset_i),
        .host       (chans[i]),
        .vram       (vreqs[i])
    );
end

vram_port_arbiter vram_port_arbiter_inst (
    .clk            (clk),
    .reset_i        (reset_i),
    .reqs           (vreqs),
    .vram_req_o     (vram_req_o),
    .vram_wr_o      (vram_wr_o),
    .vram_addr_o    (vram_addr_o),
    .vram_wdata_o   (vram_wdata_o),
    .vram_ack_i     (vram_ack_i),
    .vram_rdata_i   (vram_rdata_i)
);

endmodule

`default_nettype wire

// File: design/vram_req_if.sv
// four-phase vram request from one channel to the port arbiter
`default_nettype none
`timescale 1ns/10ps

interface vram_req_if;

logic                                   req;        // held until ack high
logic                                   wr;         // 1 write, 0 read
logic [vram_regs_pkg::ADDR_W-1:0]       addr;       // stable while req
logic [vram_regs_pkg::WORD_W-1:0]       wdata;      // stable while req
logic                                   ack;        // high until req drops
logic [vram_regs_pkg::WORD_W-1:0]       rdata;      // valid while ack

modport chan (
    output req, wr, addr, wdata,
    input  ack, rdata
);

modport arb (
    input  req, wr, addr, wdata,
    output ack, rdata
);

endinterface

`default_nettype wire

// File: project.f
design/vram_regs_pkg.sv
design/chan_if.sv
design/vram_req_if.sv
design/host_bus_port.sv
design/vram_channel.sv
design/vram_port_arbiter.sv
design/vram_regs_top.sv
tests/tb_checker.sv
tests/tb_top.sv

// File: tests/tb_checker.sv
// testbench checker comparing read-back bytes and watching the vram four-phase handshake
`default_nettype none
`timescale 1ns/10ps

module tb_checker (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           cmp_i,          // one-cycle compare request
    input  wire logic [7:0]     exp_i,          // expected byte
    input  wire logic [255:0]   name_i,         // ascii test name
    input  wire logic [7:0]     bus_data_i,     // dut read-back byte
    input  wire logic           vram_req_i,
    input  wire logic           vram_wr_i,
    input  wire logic [15:0]    vram_addr_i,
    input  wire logic [15:0]    vram_wdata_i,
    input  wire logic           vram_ack_i,
    output      int             checks_o,
    output      int             mismatches_o,
    output      int             hs_errors_o
);

logic           req_q;                          // previous cycle view of the port
logic           ack_q;
logic           wr_q;
logic [15:0]    addr_q;
logic [15:0]    wdata_q;

initial begin
    checks_o     = 0;
    mismatches_o = 0;
    hs_errors_o  = 0;
end

// byte compare sampled before this edge's updates
always @(posedge clk) begin
    if (cmp_i) begin
        checks_o = checks_o + 1;
        if (bus_data_i !== exp_i) begin
            mismatches_o = mismatches_o + 1;
            $display("MISMATCH %0s expected %02h actual %02h", name_i, exp_i, bus_data_i);
        end
    end
end

// four-phase rule at the external port
always @(posedge clk) begin
    if (reset_i) begin
        req_q   <= 1'b0;
        ack_q   <= 1'b0;
        wr_q    <= 1'b0;
        addr_q  <= '0;
        wdata_q <= '0;
    end else begin
        if (!req_q && vram_req_i && ack_q) begin
            hs_errors_o = hs_errors_o + 1;
            $display("handshake error: request rose while ack still high at %0t", $time);
        end
        if (req_q && !vram_req_i && !ack_q) begin
            hs_errors_o = hs_errors_o + 1;
            $display("handshake error: request dropped before ack at %0t", $time);
        end
        if (req_q && vram_req_i && (vram_addr_i !== addr_q || vram_wr_i !== wr_q
                                    || vram_wdata_i !== wdata_q)) begin
            hs_errors_o = hs_errors_o + 1;
            $display("handshake error: address, data or direction changed under request at %0t",
                     $time);
        end
        req_q   <= vram_req_i;
        ack_q   <= vram_ack_i;
        wr_q    <= vram_wr_i;
        addr_q  <= vram_addr_i;
        wdata_q <= vram_wdata_i;
    end
end

endmodule

`default_nettype wire

// File: tests/tb_top.sv
// testbench top with host bus driver, vram model and table driven stimulus
`default_nettype none
`timescale 1ns/10ps

module tb_top;

localparam int OP_WR   = 0;                     // host byte write
localparam int OP_RD   = 1;                     // host byte read and compare
localparam int OP_POLL = 2;                     // read STATUS until zero
localparam int OP_SLOW = 3;                     // model delay to max until next poll
localparam int POLL_TRIES = 40;
localparam int HS_LIMIT   = 100;                // cycles allowed for req release
localparam logic [15:0] MEM_PATTERN = 16'hA5C3;

logic           clk = 1'b0;
logic           reset_i;
logic           bus_cs_n_i;
logic           bus_rd_nwr_i;
logic [3:0]     bus_reg_num_i;
logic           bus_bytesel_i;
logic [7:0]     bus_data_i;
logic [7:0]     bus_data_o;
logic           vram_req_o;
logic           vram_wr_o;
logic [15:0]    vram_addr_o;
logic [15:0]    vram_wdata_o;
logic           vram_ack_i = 1'b0;              // model owned
logic [15:0]    vram_rdata_i = '0;

logic           cmp = 1'b0;
logic [7:0]     cur_exp = '0;
logic [255:0]   cur_name = '0;
logic [7:0]     last_rd;                        // byte seen by the driver
logic           force_max = 1'b0;
int             poll_timeouts = 0;
int             model_timeouts = 0;
int             checks;
int             mismatches;
int             hs_errors;
integer         seed = 32'h30861db1;

int             t_op [$];                       // stimulus table columns
logic [3:0]     t_reg [$];
logic           t_bs [$];
logic [7:0]     t_data [$];
logic [7:0]     t_exp [$];
logic [255:0]   t_name [$];

bit [15:0]      mem [65536];
bit             written [65536];                // unwritten words read the pattern
int             m_state = 0;
int             m_cnt;
int             m_wait;

always #2 clk = ~clk;                           // 4 ns period

vram_regs_top vram_regs_top_inst (
    .clk(clk), .reset_i(reset_i),
    .bus_cs_n_i(bus_cs_n_i), .bus_rd_nwr_i(bus_rd_nwr_i), .bus_reg_num_i(bus_reg_num_i),
    .bus_bytesel_i(bus_bytesel_i), .bus_data_i(bus_data_i), .bus_data_o(bus_data_o),
    .vram_req_o(vram_req_o), .vram_wr_o(vram_wr_o), .vram_addr_o(vram_addr_o),
    .vram_wdata_o(vram_wdata_o), .vram_ack_i(vram_ack_i), .vram_rdata_i(vram_rdata_i)
);

tb_checker tb_checker_inst (
    .clk(clk), .reset_i(reset_i), .cmp_i(cmp), .exp_i(cur_exp), .name_i(cur_name),
    .bus_data_i(bus_data_o), .vram_req_i(vram_req_o), .vram_wr_i(vram_wr_o),
    .vram_addr_i(vram_addr_o), .vram_wdata_i(vram_wdata_o), .vram_ack_i(vram_ack_i),
    .checks_o(checks), .mismatches_o(mismatches), .hs_errors_o(hs_errors)
);

function automatic logic [15:0] init_word(input logic [15:0] a);
    return a ^ MEM_PATTERN;                     // power-up content
endfunction

function automatic logic [3:0] rn(input int c, input vram_regs_pkg::reg_field_e f);
    return {2'(c), f};                          // channel index then field
endfunction

function automatic int pick_delay();
    int d;
    d = 1 + int'($unsigned($random(seed)) % 4);
    if (force_max) d = 4;
    return d;
endfunction

// four-phase responder with delay on both phases
always @(posedge clk) begin
    if (reset_i) begin
        m_state = 0;
        vram_ack_i <= #1 1'b0;
    end else begin
        case (m_state)
            0: if (vram_req_o) begin
                m_cnt   = pick_delay();
                m_state = 1;
            end
            1: if (m_cnt <= 1) begin
                if (vram_wr_o) begin
                    mem[vram_addr_o]     = vram_wdata_o;
                    written[vram_addr_o] = 1'b1;
                end else begin
                    vram_rdata_i <= #1 (written[vram_addr_o] ? mem[vram_addr_o]
                                                             : init_word(vram_addr_o));
                end
                vram_ack_i <= #1 1'b1;
                m_wait  = 0;
                m_state = 2;
            end else begin
                m_cnt = m_cnt - 1;
            end
            2: if (!vram_req_o) begin
                m_cnt   = pick_delay();
                m_state = 3;
            end else if (m_wait >= HS_LIMIT) begin
                $display("vram model: request never released after ack");
                model_timeouts = model_timeouts + 1;
                m_cnt   = 1;
                m_state = 3;                    // drop ack anyway
            end else begin
                m_wait = m_wait + 1;
            end
            default: if (m_cnt <= 1) begin
                vram_ack_i <= #1 1'b0;
                m_state = 0;
            end else begin
                m_cnt = m_cnt - 1;
            end
        endcase
    end
end

task automatic add_step(input int op, input logic [3:0] r, input logic bs,
                        input logic [7:0] d, input logic [7:0] e, input logic [255:0] n);
    t_op.push_back(op);
    t_reg.push_back(r);
    t_bs.push_back(bs);
    t_data.push_back(d);
    t_exp.push_back(e);
    t_name.push_back(n);
endtask

// entered and left 1 ns after a rising edge
task automatic bus_cycle(input logic rd, input logic [3:0] r, input logic bs,
                         input logic [7:0] d, input logic chk);
    bus_cs_n_i    = 1'b0;
    bus_rd_nwr_i  = rd;
    bus_reg_num_i = r;
    bus_bytesel_i = bs;
    bus_data_i    = d;
    for (int i = 1; i <= 6; i++) begin
        @(posedge clk);
        #1;
        if (i == 4) cmp = chk;                  // checker samples on 5th edge
        if (i == 5) begin
            cmp     = 1'b0;
            last_rd = bus_data_o;
        end
    end
    bus_cs_n_i = 1'b1;
    repeat (4) begin
        @(posedge clk);
        #1;
    end
endtask

task automatic poll_status(output logic timed_out);
    int tries;
    tries     = 0;
    timed_out = 1'b1;
    force_max = 1'b0;
    while (tries < POLL_TRIES) begin
        bus_cycle(1'b1, vram_regs_pkg::STATUS_REG_NUM, 1'b1, 8'h00, 1'b0);
        if (last_rd == 8'h00) begin
            timed_out = 1'b0;
            break;
        end
        tries++;
    end
endtask

task automatic build_table();
    logic [15:0] incr_v [3];
    logic [15:0] addr_v [3];
    logic [15:0] a;
    logic [15:0] pre_w;                         // model word at the written address
    logic [15:0] ref_w;                         // model word one step further
    incr_v = '{16'h1357, 16'h0011, 16'h00F0};
    addr_v = '{16'h2468, 16'h4000, 16'h8001};
    add_step(OP_RD, vram_regs_pkg::STATUS_REG_NUM, 1'b0, 8'h00, 8'h00, "status idle hi");
    add_step(OP_RD, vram_regs_pkg::STATUS_REG_NUM, 1'b1, 8'h00, 8'h00, "status idle lo");
    add_step(OP_RD, 4'd3, 1'b1, 8'h00, 8'h00, "reserved 3");
    add_step(OP_RD, 4'd13, 1'b0, 8'h00, 8'h00, "reserved 13");
    add_step(OP_RD, 4'd15, 1'b1, 8'h00, 8'h00, "reserved 15");
    for (int c = 0; c < 3; c++) begin
        a     = addr_v[c] + incr_v[c];          // pre-read steps once
        pre_w = init_word(addr_v[c]);
        ref_w = init_word(a);
        add_step(OP_WR, rn(c, vram_regs_pkg::FIELD_INCR), 1'b0, incr_v[c][15:8], 0, "");
        add_step(OP_WR, rn(c, vram_regs_pkg::FIELD_INCR), 1'b1, incr_v[c][7:0], 0, "");
        add_step(OP_RD, rn(c, vram_regs_pkg::FIELD_INCR), 1'b0, 0, incr_v[c][15:8], "incr hi");
        add_step(OP_RD, rn(c, vram_regs_pkg::FIELD_INCR), 1'b1, 0, incr_v[c][7:0], "incr lo");
        add_step(OP_WR, rn(c, vram_regs_pkg::FIELD_ADDR), 1'b0, addr_v[c][15:8], 0, "");
        add_step(OP_WR, rn(c, vram_regs_pkg::FIELD_ADDR), 1'b1, addr_v[c][7:0], 0, "");
        add_step(OP_POLL, 0, 0, 0, 0, "");
        add_step(OP_RD, rn(c, vram_regs_pkg::FIELD_ADDR), 1'b0, 0, a[15:8], "addr hi");
        add_step(OP_RD, rn(c, vram_regs_pkg::FIELD_ADDR), 1'b1, 0, a[7:0], "addr lo");
        add_step(OP_RD, rn(c, vram_regs_pkg::FIELD_DATA), 1'b0, 0, pre_w[15:8], "preread hi");
        add_step(OP_RD, rn(c, vram_regs_pkg::FIELD_DATA), 1'b1, 0, pre_w[7:0], "preread lo");
        add_step(OP_POLL, 0, 0, 0, 0, "");
        add_step(OP_RD, rn(c, vram_regs_pkg::FIELD_DATA), 1'b0, 0, ref_w[15:8], "refill hi");
    end
    // write and advance on channel 0 with incr 1
    add_step(OP_WR, 4'd0, 1'b0, 8'h00, 0, "");
    add_step(OP_WR, 4'd0, 1'b1, 8'h01, 0, "");
    add_step(OP_WR, 4'd1, 1'b0, 8'h01, 0, "");
    add_step(OP_WR, 4'd1, 1'b1, 8'h00, 0, "");  // pre-read 0100
    add_step(OP_POLL, 0, 0, 0, 0, "");
    add_step(OP_WR, 4'd2, 1'b0, 8'hBE, 0, "");
    add_step(OP_WR, 4'd2, 1'b1, 8'hEF, 0, "");  // beef at 0101
    add_step(OP_WR, 4'd2, 1'b0, 8'hCA, 0, "");
    add_step(OP_WR, 4'd2, 1'b1, 8'hFE, 0, "");  // cafe at 0102
    add_step(OP_POLL, 0, 0, 0, 0, "");
    add_step(OP_RD, 4'd1, 1'b0, 0, 8'h01, "advance addr hi");
    add_step(OP_RD, 4'd1, 1'b1, 0, 8'h03, "advance addr lo");
    // read back through channel 1
    add_step(OP_WR, 4'd4, 1'b0, 8'h00, 0, "");
    add_step(OP_WR, 4'd4, 1'b1, 8'h01, 0, "");
    add_step(OP_WR, 4'd5, 1'b0, 8'h01, 0, "");
    add_step(OP_WR, 4'd5, 1'b1, 8'h01, 0, "");
    add_step(OP_POLL, 0, 0, 0, 0, "");
    add_step(OP_RD, 4'd6, 1'b0, 0, 8'hBE, "written word1 hi");
    add_step(OP_RD, 4'd6, 1'b1, 0, 8'hEF, "written word1 lo");
    add_step(OP_POLL, 0, 0, 0, 0, "");
    add_step(OP_RD, 4'd6, 1'b0, 0, 8'hCA, "written word2 hi");
    add_step(OP_RD, 4'd6, 1'b1, 0, 8'hFE, "written word2 lo");
    add_step(OP_POLL, 0, 0, 0, 0, "");
    // channels 0 and 2 back to back
    add_step(OP_WR, 4'd8, 1'b0, 8'h00, 0, "");
    add_step(OP_WR, 4'd8, 1'b1, 8'h01, 0, "");
    add_step(OP_WR, 4'd9, 1'b0, 8'h02, 0, "");
    add_step(OP_WR, 4'd9, 1'b1, 8'h00, 0, "");
    add_step(OP_POLL, 0, 0, 0, 0, "");
    add_step(OP_WR, 4'd2, 1'b0, 8'h11, 0, "");
    add_step(OP_WR, 4'd2, 1'b1, 8'h22, 0, "");  // 1122 at 0103
    add_step(OP_WR, 4'd10, 1'b0, 8'h33, 0, "");
    add_step(OP_WR, 4'd10, 1'b1, 8'h44, 0, ""); // 3344 at 0201
    add_step(OP_POLL, 0, 0, 0, 0, "");
    add_step(OP_WR, 4'd5, 1'b0, 8'h01, 0, "");
    add_step(OP_WR, 4'd5, 1'b1, 8'h03, 0, "");
    add_step(OP_POLL, 0, 0, 0, 0, "");
    add_step(OP_RD, 4'd6, 1'b0, 0, 8'h11, "concurrent ch0 hi");
    add_step(OP_RD, 4'd6, 1'b1, 0, 8'h22, "concurrent ch0 lo");
    add_step(OP_POLL, 0, 0, 0, 0, "");
    add_step(OP_WR, 4'd5, 1'b0, 8'h02, 0, "");
    add_step(OP_WR, 4'd5, 1'b1, 8'h01, 0, "");
    add_step(OP_POLL, 0, 0, 0, 0, "");
    add_step(OP_RD, 4'd6, 1'b0, 0, 8'h33, "concurrent ch2 hi");
    add_step(OP_RD, 4'd6, 1'b1, 0, 8'h44, "concurrent ch2 lo");
    add_step(OP_POLL, 0, 0, 0, 0, "");
    // busy bit and dropped command with ch0 at 0104
    add_step(OP_SLOW, 0, 0, 0, 0, "");
    add_step(OP_WR, 4'd2, 1'b1, 8'h55, 0, "");
    add_step(OP_RD, vram_regs_pkg::STATUS_REG_NUM, 1'b1, 0, 8'h01, "status busy ch0");
    add_step(OP_POLL, 0, 0, 0, 0, "");
    add_step(OP_SLOW, 0, 0, 0, 0, "");
    add_step(OP_WR, 4'd2, 1'b1, 8'h66, 0, "");  // launches at 0105
    add_step(OP_WR, 4'd2, 1'b1, 8'h77, 0, "");  // busy so dropped
    add_step(OP_POLL, 0, 0, 0, 0, "");
    add_step(OP_RD, 4'd1, 1'b0, 0, 8'h01, "backpressure addr hi");
    add_step(OP_RD, 4'd1, 1'b1, 0, 8'h06, "backpressure addr lo");
endtask

initial begin
    logic tmo;
    bus_cs_n_i    = 1'b1;
    bus_rd_nwr_i  = 1'b1;
    bus_reg_num_i = '0;
    bus_bytesel_i = 1'b0;
    bus_data_i    = '0;
    reset_i       = 1'b1;
    build_table();
    repeat (10) @(posedge clk);
    #1;
    reset_i = 1'b0;
    for (int i = 0; i < t_op.size() && poll_timeouts == 0; i++) begin
        cur_exp  = t_exp[i];
        cur_name = t_name[i];
        case (t_op[i])
            OP_WR:   bus_cycle(1'b0, t_reg[i], t_bs[i], t_data[i], 1'b0);
            OP_RD:   bus_cycle(1'b1, t_reg[i], t_bs[i], 8'h00, 1'b1);
            OP_SLOW: force_max = 1'b1;
            default: begin
                poll_status(tmo);
                if (tmo) begin
                    $display("timeout: STATUS never returned to zero at table step %0d", i);
                    poll_timeouts = poll_timeouts + 1;
                end
            end
        endcase
    end
    repeat (20) @(posedge clk);
    $display("checks %0d, mismatches %0d, handshake errors %0d, timeouts %0d",
             checks, mismatches, hs_errors, poll_timeouts + model_timeouts);
    if (mismatches == 0 && hs_errors == 0 && poll_timeouts == 0 && model_timeouts == 0) begin
        $display("TESTBENCH PASSED");
    end else begin
        $display("TESTBENCH FAILED");
    end
    $finish;
end

endmodule

`default_nettype wire
